// File: hw/alu.sv
`timescale 1ns/1ns

module alu (
    input  rv32i_pkg::alu_op_e alu_op,
    input  logic               alu_alt,
    input  rv32i_pkg::word_t   a,
    input  rv32i_pkg::word_t   b,
    output rv32i_pkg::word_t   f
);
    import rv32i_pkg::*;

    logic [4:0] shamt;
    word_t      sra_res;

    assign shamt   = b[4:0];
    assign sra_res = $signed(a) >>> shamt; // keeps the sign bit

    always_comb begin
        case (alu_op)
            alu_add:  f = alu_alt ? a - b : a + b;
            alu_sll:  f = a << shamt;
            alu_slt:  f = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: f = {31'b0, a < b};
            alu_xor:  f = a ^ b;
            alu_srl:  f = alu_alt ? sra_res : a >> shamt;
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            default:  f = a + b;
        endcase
    end

endmodule : alu

// File: hw/cpu.sv
`timescale 1ns/1ns

module cpu (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic                  instr_read,
    output rv32i_pkg::word_t      instr_mem_address,
    input  rv32i_pkg::word_t      instr_mem_rdata,
    input  logic                  instr_mem_resp,
    output logic                  data_read,
    output logic                  data_write,
    output rv32i_pkg::word_t      data_mem_address,
    input  rv32i_pkg::word_t      data_mem_rdata,
    input  logic                  data_mem_resp,
    output rv32i_pkg::byte_mask_t data_mbe,
    output rv32i_pkg::word_t      data_mem_wdata
);
    import rv32i_pkg::*;

    word_t      pc;
    word_t      if_id_pc;
    word_t      if_id_ir;
    ctrl_word_t id_ctrl;
    word_t      id_imm;
    word_t      rf_a;
    word_t      rf_b;
    ctrl_word_t id_ex_ctrl;
    word_t      id_ex_pc;
    word_t      id_ex_imm;
    word_t      id_ex_rs1;
    word_t      id_ex_rs2;
    fwd_sel_e   fwd_a_sel;
    fwd_sel_e   fwd_b_sel;
    word_t      fwd_a;
    word_t      fwd_b;
    word_t      alu_f;
    byte_mask_t ex_mbe;
    word_t      ex_wdata;
    ctrl_word_t ex_mem_ctrl;
    word_t      ex_mem_alu;
    byte_mask_t ex_mem_mbe;
    word_t      ex_mem_wdata;
    ctrl_word_t mem_wb_ctrl;
    word_t      mem_wb_alu;
    word_t      mem_wb_rdata;
    word_t      wb_load_data;
    word_t      wb_value;
    logic       global_stall;
    logic       load_use_stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            if_id_pc <= RESET_PC;
            if_id_ir <= NOP_INSTR;
        end else if (!global_stall && !load_use_stall) begin
            pc       <= pc + 32'd4; // no control flow, always sequential
            if_id_pc <= pc;
            if_id_ir <= instr_mem_rdata;
        end
    end

    rv32i_decoder u_decoder (.instr(if_id_ir), .ctrl(id_ctrl), .imm(id_imm));

    regfile u_regfile (
        .clk(clk), .rst_n(rst_n),
        .load(mem_wb_ctrl.load_regfile), .dest(mem_wb_ctrl.rd_id), .in(wb_value),
        .src_a(id_ctrl.rs1_id), .src_b(id_ctrl.rs2_id), .reg_a(rf_a), .reg_b(rf_b)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_ctrl <= BUBBLE_CTRL;
        end else if (!global_stall) begin
            id_ex_ctrl <= load_use_stall ? BUBBLE_CTRL : id_ctrl; // bubble behind a load
        end
    end

    always_ff @(posedge clk) begin
        if (!global_stall) begin
            id_ex_pc  <= if_id_pc;
            id_ex_imm <= id_imm;
            id_ex_rs1 <= rf_a;
            id_ex_rs2 <= rf_b;
        end
    end

    always_comb begin
        case (fwd_a_sel)
            fwd_mem: fwd_a = ex_mem_alu;
            fwd_wb:  fwd_a = wb_value;
            default: fwd_a = id_ex_rs1;
        endcase
        case (fwd_b_sel)
            fwd_mem: fwd_b = ex_mem_alu;
            fwd_wb:  fwd_b = wb_value;
            default: fwd_b = id_ex_rs2;
        endcase
    end

    alu u_alu (
        .alu_op(id_ex_ctrl.alu_op), .alu_alt(id_ex_ctrl.alu_alt),
        .a(id_ex_ctrl.alu_a_pc ? id_ex_pc : fwd_a),
        .b(id_ex_ctrl.alu_b_imm ? id_ex_imm : fwd_b), .f(alu_f)
    );

    // lane mask and store placement, registered with the access
    lsu_align u_store_align (
        .funct3(id_ex_ctrl.funct3), .byte_offset(alu_f[1:0]), .store_data(fwd_b),
        .mem_rdata('0), .mbe(ex_mbe), .mem_wdata(ex_wdata), .load_data()
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_ctrl  <= BUBBLE_CTRL;
            ex_mem_alu   <= '0;
            ex_mem_mbe   <= '0;
            ex_mem_wdata <= '0;
        end else if (!global_stall) begin // request stays steady while waiting
            ex_mem_ctrl  <= id_ex_ctrl;
            ex_mem_alu   <= alu_f;
            ex_mem_mbe   <= ex_mbe;
            ex_mem_wdata <= ex_wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb_ctrl <= BUBBLE_CTRL;
        end else if (!global_stall) begin
            mem_wb_ctrl <= ex_mem_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (!global_stall) begin
            mem_wb_alu   <= ex_mem_alu;
            mem_wb_rdata <= data_mem_rdata;
        end
    end

    lsu_align u_load_align (
        .funct3(mem_wb_ctrl.funct3), .byte_offset(mem_wb_alu[1:0]), .store_data('0),
        .mem_rdata(mem_wb_rdata), .mbe(), .mem_wdata(), .load_data(wb_load_data)
    );

    assign wb_value = (mem_wb_ctrl.wb_sel == wb_load) ? wb_load_data : mem_wb_alu;

    hazard_unit u_hazard (
        .instr_mem_resp(instr_mem_resp), .data_mem_resp(data_mem_resp),
        .id_ctrl(id_ctrl), .ex_ctrl(id_ex_ctrl), .mem_ctrl(ex_mem_ctrl), .wb_ctrl(mem_wb_ctrl),
        .global_stall(global_stall), .load_use_stall(load_use_stall),
        .fwd_a_sel(fwd_a_sel), .fwd_b_sel(fwd_b_sel)
    );

    assign instr_read        = 1'b1;
    assign instr_mem_address = pc;
    assign data_read         = ex_mem_ctrl.mem_read;
    assign data_write        = ex_mem_ctrl.mem_write;
    assign data_mem_address  = {ex_mem_alu[31:2], 2'b00};
    assign data_mbe          = ex_mem_mbe;
    assign data_mem_wdata    = ex_mem_wdata;

endmodule : cpu

// File: hw/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit (
    input  logic                  instr_mem_resp,
    input  logic                  data_mem_resp,
    input  rv32i_pkg::ctrl_word_t id_ctrl,  // instruction being decoded
    input  rv32i_pkg::ctrl_word_t ex_ctrl,  // id/ex
    input  rv32i_pkg::ctrl_word_t mem_ctrl, // ex/mem
    input  rv32i_pkg::ctrl_word_t wb_ctrl,  // mem/wb
    output logic                  global_stall,
    output logic                  load_use_stall,
    output rv32i_pkg::fwd_sel_e   fwd_a_sel,
    output rv32i_pkg::fwd_sel_e   fwd_b_sel
);
    import rv32i_pkg::*;

    logic data_busy;
    logic load_in_ex;

    function automatic fwd_sel_e fwd_select(input reg_id_t src, input ctrl_word_t mem_c,
                                            input ctrl_word_t wb_c);
        fwd_sel_e sel;
        sel = fwd_none;
        if (src != 5'd0) begin
            // a load in ex/mem has no data yet, the interlock covers it
            if (mem_c.load_regfile && mem_c.opcode != op_load && mem_c.rd_id == src) begin
                sel = fwd_mem;
            end else if (wb_c.load_regfile && wb_c.rd_id == src) begin
                sel = fwd_wb;
            end
        end
        return sel;
    endfunction

    assign data_busy    = (mem_ctrl.mem_read || mem_ctrl.mem_write) && !data_mem_resp;
    assign global_stall = !instr_mem_resp || data_busy;

    assign load_in_ex = (ex_ctrl.opcode == op_load) && (ex_ctrl.rd_id != 5'd0);

    assign load_use_stall = !global_stall && load_in_ex &&
                            (ex_ctrl.rd_id == id_ctrl.rs1_id ||
                             ex_ctrl.rd_id == id_ctrl.rs2_id);

    assign fwd_a_sel = fwd_select(ex_ctrl.rs1_id, mem_ctrl, wb_ctrl);
    assign fwd_b_sel = fwd_select(ex_ctrl.rs2_id, mem_ctrl, wb_ctrl);

endmodule : hazard_unit

// File: hw/lsu_align.sv
`timescale 1ns/1ns

module lsu_align (
    input  rv32i_pkg::mem_funct3_e funct3,
    input  logic [1:0]             byte_offset,
    input  rv32i_pkg::word_t       store_data,
    input  rv32i_pkg::word_t       mem_rdata,
    output rv32i_pkg::byte_mask_t  mbe,
    output rv32i_pkg::word_t       mem_wdata,
    output rv32i_pkg::word_t       load_data
);
    import rv32i_pkg::*;

    logic [4:0] byte_shift;
    logic [4:0] half_shift;
    word_t      rdata_shifted;

    assign byte_shift = {byte_offset, 3'b000};
    assign half_shift = {byte_offset[1], 4'b0000}; // halves sit on lanes 0-1 or 2-3

    // addressed lanes moved down to bit 0
    assign rdata_shifted = mem_rdata >> byte_shift;

    always_comb begin
        case (funct3)
            lb, lbu: begin
                mbe       = 4'b0001 << byte_offset;
                mem_wdata = {24'b0, store_data[7:0]} << byte_shift;
            end
            lh, lhu: begin
                mbe       = 4'b0011 << {byte_offset[1], 1'b0};
                mem_wdata = {16'b0, store_data[15:0]} << half_shift;
            end
            default: begin
                mbe       = 4'b1111; // word
                mem_wdata = store_data;
            end
        endcase
    end

    always_comb begin
        case (funct3)
            lb: begin
                load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
            end
            lbu: begin
                load_data = {24'b0, rdata_shifted[7:0]};
            end
            lh: begin
                load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
            end
            lhu: begin
                load_data = {16'b0, rdata_shifted[15:0]};
            end
            default: begin
                load_data = mem_rdata;
            end
        endcase
    end

endmodule : lsu_align

// File: hw/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,
    input  rv32i_pkg::reg_id_t dest,
    input  rv32i_pkg::word_t   in,
    input  rv32i_pkg::reg_id_t src_a,
    input  rv32i_pkg::reg_id_t src_b,
    output rv32i_pkg::word_t   reg_a,
    output rv32i_pkg::word_t   reg_b
);
    import rv32i_pkg::*;

    word_t regs [31:1]; // x0 has no storage
    logic  write_en;

    assign write_en = load && (dest != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[dest] <= in;
        end
    end

    // same-cycle write shows up on the read ports
    assign reg_a = (src_a == 5'd0) ? '0 : (write_en && dest == src_a) ? in : regs[src_a];
    assign reg_b = (src_b == 5'd0) ? '0 : (write_en && dest == src_b) ? in : regs[src_b];

endmodule : regfile

// File: hw/rv32i_decoder.sv
`timescale 1ns/1ns

module rv32i_decoder (
    input  rv32i_pkg::word_t      instr,
    output rv32i_pkg::ctrl_word_t ctrl,
    output rv32i_pkg::word_t      imm
);
    import rv32i_pkg::*;

    rv32i_opcode_e opcode;
    logic [2:0]    funct3;
    reg_id_t       rs1;
    reg_id_t       rs2;
    reg_id_t       rd;
    word_t         i_imm;
    word_t         s_imm;
    word_t         u_imm;

    assign opcode = rv32i_opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign u_imm = {instr[31:12], 12'b0};

    always_comb begin
        ctrl = BUBBLE_CTRL; // unknown opcodes stay a bubble
        imm  = '0;
        case (opcode)
            op_lui: begin
                ctrl.opcode       = op_lui;
                ctrl.rd_id        = rd;
                ctrl.load_regfile = 1'b1;
                imm               = u_imm; // x0 + imm
            end
            op_auipc: begin
                ctrl.opcode       = op_auipc;
                ctrl.alu_a_pc     = 1'b1;
                ctrl.rd_id        = rd;
                ctrl.load_regfile = 1'b1;
                imm               = u_imm;
            end
            op_imm: begin
                ctrl.opcode       = op_imm;
                ctrl.alu_op       = alu_op_e'(funct3);
                ctrl.alu_alt      = (funct3 == 3'b101) && instr[30]; // srai only
                ctrl.rs1_id       = rs1;
                ctrl.rd_id        = rd;
                ctrl.load_regfile = 1'b1;
                imm               = i_imm;
            end
            op_reg: begin
                ctrl.opcode       = op_reg;
                ctrl.alu_op       = alu_op_e'(funct3);
                ctrl.alu_alt      = instr[30];
                ctrl.alu_b_imm    = 1'b0;
                ctrl.rs1_id       = rs1;
                ctrl.rs2_id       = rs2;
                ctrl.rd_id        = rd;
                ctrl.load_regfile = 1'b1;
            end
            op_load: begin
                ctrl.opcode       = op_load;
                ctrl.funct3       = mem_funct3_e'(funct3);
                ctrl.mem_read     = 1'b1;
                ctrl.wb_sel       = wb_load;
                ctrl.rs1_id       = rs1;
                ctrl.rd_id        = rd;
                ctrl.load_regfile = 1'b1;
                imm               = i_imm;
            end
            op_store: begin
                ctrl.opcode    = op_store;
                ctrl.funct3    = mem_funct3_e'(funct3);
                ctrl.mem_write = 1'b1;
                ctrl.rs1_id    = rs1;
                ctrl.rs2_id    = rs2; // store data
                imm            = s_imm;
            end
            default: ;
        endcase
    end

endmodule : rv32i_decoder

// File: hw/rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_id_t;
    typedef logic [3:0]  byte_mask_t; // bit i enables byte lane i

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_imm   = 7'b0010011, // register-immediate alu ops
        op_reg   = 7'b0110011, // register-register alu ops
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } rv32i_opcode_e;

    // funct3 of the alu ops, sub and sra come from alu_alt
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_srl  = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_e;

    typedef enum logic [2:0] {
        lb  = 3'b000, // sb for stores
        lh  = 3'b001, // sh for stores
        lw  = 3'b010, // sw for stores
        lbu = 3'b100,
        lhu = 3'b101
    } mem_funct3_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load
    } wb_sel_e;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem, // from ex/mem alu result
        fwd_wb   // from the writeback value
    } fwd_sel_e;

    typedef struct packed {
        rv32i_opcode_e opcode;
        alu_op_e       alu_op;
        logic          alu_alt;   // sub / sra
        logic          alu_a_pc;  // pc instead of rs1
        logic          alu_b_imm; // imm instead of rs2
        mem_funct3_e   funct3;    // access size and sign
        logic          mem_read;
        logic          mem_write;
        logic          load_regfile;
        wb_sel_e       wb_sel;
        reg_id_t       rs1_id;    // 0 when not read
        reg_id_t       rs2_id;    // 0 when not read
        reg_id_t       rd_id;
    } ctrl_word_t;

    localparam word_t RESET_PC  = 32'h0000_0000;
    localparam word_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    // control word of a pipeline bubble, writes nothing
    localparam ctrl_word_t BUBBLE_CTRL = '{
        opcode:       op_imm,
        alu_op:       alu_add,
        alu_alt:      1'b0,
        alu_a_pc:     1'b0,
        alu_b_imm:    1'b1,
        funct3:       lw,
        mem_read:     1'b0,
        mem_write:    1'b0,
        load_regfile: 1'b0,
        wb_sel:       wb_alu,
        rs1_id:       5'd0,
        rs2_id:       5'd0,
        rd_id:        5'd0
    };

endpackage : rv32i_pkg

// File: project.f
+incdir+tb
hw/rv32i_pkg.sv
hw/rv32i_decoder.sv
hw/regfile.sv
hw/alu.sv
hw/lsu_align.sv
hw/hazard_unit.sv
hw/cpu.sv
tb/tb_cpu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --top-module tb_cpu -f project.f -o sim_cpu
./obj_dir/sim_cpu > sim.log 2>&1 || true
cat sim.log
if grep -q "Something failed" sim.log; then
    exit 1
fi
grep -q "Everything OK" sim.log

// File: tb/rv32i_model.svh
`ifndef RV32I_MODEL_SVH
`define RV32I_MODEL_SVH

localparam int PROG_LEN = 200; // random instructions before the NOP fill

logic [31:0] rng_state;
word_t       m_regs [32];
word_t       m_mem [64];
word_t       exp_addr [$]; // stores in program order
byte_mask_t  exp_mbe [$];
word_t       exp_data [$];

// LCG step that hands out only its upper 24 bits
function automatic int unsigned rand_below(int unsigned n);
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {8'd0, rng_state[31:8]} % n;
endfunction

function automatic word_t fill_pattern(int unsigned idx);
    return (idx * 32'h9e37_79b1) ^ 32'hc3a5_0f00;
endfunction

function automatic logic [11:0] aligned_offset(logic [1:0] size);
    logic [11:0] off;
    off = 12'(4 * rand_below(64)); // inside the 64-word window
    if (size == 2'd0) begin
        off[1:0] = 2'(rand_below(4));
    end else if (size == 2'd1) begin
        off[1] = rand_below(2) == 1;
    end
    return off;
endfunction

function automatic word_t store_word(reg_id_t src, logic [11:0] off);
    return {off[11:5], src, 5'd0, 3'b010, off[4:0], 7'b0100011}; // sw src, off(x0)
endfunction

function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

task automatic gen_program();
    int unsigned n;
    int unsigned k;
    logic [2:0]  f3;
    reg_id_t     rd;
    reg_id_t     rs1;
    reg_id_t     rs2;
    logic [11:0] imm;
    logic        alt;
    n = 0;
    while (n < PROG_LEN - 1) begin
        k   = rand_below(8);
        rd  = 5'(rand_below(7) + 1); // few registers give many dependencies
        rs1 = 5'(rand_below(8));
        rs2 = 5'(rand_below(8));
        f3  = 3'(rand_below(8));
        alt = rand_below(2) == 1;
        case (k)
            0, 1, 7: begin
                imem[n] = {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                           rs2, rs1, f3, rd, 7'b0110011};
                n++;
                if (k == 7) begin // make the result visible right away
                    imem[n] = store_word(rd, aligned_offset(2'd2));
                    n++;
                end
            end
            2: begin
                imm = 12'(rand_below(4096));
                if (f3 == 3'd1) begin
                    imm[11:5] = 7'h00;
                end
                if (f3 == 3'd5) begin
                    imm[11:5] = alt ? 7'h20 : 7'h00;
                end
                imem[n] = {imm, rs1, f3, rd, 7'b0010011};
                n++;
            end
            3: begin
                imem[n] = {rng_state[31:12], rd, alt ? 7'b0110111 : 7'b0010111};
                n++;
            end
            4, 5: begin
                f3  = 3'(rand_below(3));
                imm = aligned_offset(f3[1:0]);
                imem[n] = {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
                n++;
            end
            default: begin
                case (rand_below(5))
                    0:       f3 = 3'd0;
                    1:       f3 = 3'd1;
                    2:       f3 = 3'd2;
                    3:       f3 = 3'd4;
                    default: f3 = 3'd5;
                endcase
                imm = aligned_offset(f3[1:0]);
                imem[n] = {imm, 5'd0, f3, rd, 7'b0000011};
                imem[n + 1] = store_word(rd, aligned_offset(2'd2)); // load-use
                n += 2;
            end
        endcase
    end
    while (n < 256) begin
        imem[n] = NOP_INSTR;
        n++;
    end
endtask

// in-order ISA model that records every store as the bus shows it
task automatic run_model();
    word_t       w;
    word_t       a;
    word_t       b;
    word_t       res;
    word_t       addr;
    word_t       word;
    word_t       data;
    byte_mask_t  mask;
    logic [1:0]  off;
    logic        wr;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    for (int i = 0; i < 32; i++) begin
        m_regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        m_mem[i] = fill_pattern(i);
    end
    for (int i = 0; i < 256; i++) begin
        w   = imem[i];
        a   = m_regs[w[19:15]];
        b   = m_regs[w[24:20]];
        wr  = 1'b1;
        res = '0;
        case (w[6:0])
            7'b0110111: res = {w[31:12], 12'h000};
            7'b0010111: res = 32'(i * 4) + {w[31:12], 12'h000};
            7'b0010011: res = alu_ref(w[14:12], w[14:12] == 3'd5 && w[30], a,
                                      {{20{w[31]}}, w[31:20]});
            7'b0110011: res = alu_ref(w[14:12], w[30], a, b);
            7'b0000011: begin
                addr      = a + {{20{w[31]}}, w[31:20]};
                word      = m_mem[addr[7:2]];
                lane_byte = word[8*addr[1:0] +: 8];
                lane_half = word[16*addr[1] +: 16];
                case (w[14:12])
                    3'd0:    res = {{24{lane_byte[7]}}, lane_byte};
                    3'd1:    res = {{16{lane_half[15]}}, lane_half};
                    3'd4:    res = {24'h0, lane_byte};
                    3'd5:    res = {16'h0, lane_half};
                    default: res = word;
                endcase
            end
            7'b0100011: begin
                wr   = 1'b0;
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                off  = addr[1:0];
                case (w[13:12])
                    2'd0: begin
                        mask             = '0;
                        mask[off]        = 1'b1;
                        data             = '0;
                        data[8*off +: 8] = b[7:0];
                    end
                    2'd1: begin
                        mask = off[1] ? 4'b1100 : 4'b0011;
                        data = off[1] ? {b[15:0], 16'h0} : {16'h0, b[15:0]};
                    end
                    default: begin
                        mask = 4'b1111;
                        data = b;
                    end
                endcase
                exp_addr.push_back({addr[31:2], 2'b00});
                exp_mbe.push_back(mask);
                exp_data.push_back(data);
                for (int j = 0; j < 4; j++) begin
                    if (mask[j]) begin
                        m_mem[addr[7:2]][8*j +: 8] = data[8*j +: 8];
                    end
                end
            end
            default: wr = 1'b0;
        endcase
        if (wr && w[11:7] != 5'd0) begin
            m_regs[w[11:7]] = res;
        end
    end
endtask

`endif

// File: tb/tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu;
    import rv32i_pkg::*;

    localparam int FETCH_TIMEOUT = 64;
    localparam int STORE_TIMEOUT = 20000;

    logic       clk;
    logic       rst_n;
    logic       instr_read;
    word_t      instr_mem_address;
    word_t      instr_mem_rdata;
    logic       instr_mem_resp;
    logic       data_read;
    logic       data_write;
    word_t      data_mem_address;
    word_t      data_mem_rdata;
    logic       data_mem_resp;
    byte_mask_t data_mbe;
    word_t      data_mem_wdata;

    word_t      imem [256];
    word_t      dmem [64];
    logic [1:0] i_wait;
    logic [1:0] d_wait;
    logic       seen_fetch;
    word_t      last_fetch;
    int         store_idx;
    int         cycles;

    `include "rv32i_model.svh"

    cpu u_dut (
        .clk(clk), .rst_n(rst_n),
        .instr_read(instr_read), .instr_mem_address(instr_mem_address),
        .instr_mem_rdata(instr_mem_rdata), .instr_mem_resp(instr_mem_resp),
        .data_read(data_read), .data_write(data_write), .data_mem_address(data_mem_address),
        .data_mem_rdata(data_mem_rdata), .data_mem_resp(data_mem_resp),
        .data_mbe(data_mbe), .data_mem_wdata(data_mem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s got %b expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_mask(string name, byte_mask_t got, byte_mask_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s got %b expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_fetch(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    function automatic word_t lane_bits(byte_mask_t m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    // each memory answers after 0 to 3 wait cycles
    always @(posedge clk) begin : memories
        word_t merged;
        if (rst_n) begin
            if (instr_mem_resp) begin
                instr_mem_resp <= 1'b0;
                i_wait         <= 2'(rand_below(4));
            end else if (i_wait != 2'd0) begin
                i_wait <= i_wait - 2'd1;
            end else if (instr_read) begin
                instr_mem_rdata <= imem[instr_mem_address[9:2]];
                instr_mem_resp  <= 1'b1;
            end
            if (data_mem_resp) begin
                data_mem_resp <= 1'b0;
                d_wait        <= 2'(rand_below(4));
            end else if (data_read || data_write) begin
                if (d_wait != 2'd0) begin
                    d_wait <= d_wait - 2'd1;
                end else begin
                    merged = dmem[data_mem_address[7:2]];
                    for (int j = 0; j < 4; j++) begin
                        if (data_write && data_mbe[j]) begin
                            merged[8*j +: 8] = data_mem_wdata[8*j +: 8];
                        end
                    end
                    dmem[data_mem_address[7:2]] <= merged;
                    data_mem_rdata              <= dmem[data_mem_address[7:2]];
                    data_mem_resp               <= 1'b1;
                end
            end
        end
    end

    // a store counts once on the edge where the pipeline moves on
    always @(posedge clk) begin
        if (!seen_fetch) begin
            if (data_read || data_write) begin
                $display("data access seen before the first instruction fetch response");
                stop_on_failure();
            end
            check_fetch("instr_mem_address", instr_mem_address, RESET_PC);
        end
        if (rst_n) begin
            check_bit("instr_read", instr_read, 1'b1);
        end
        if (rst_n && instr_mem_resp) begin
            if (seen_fetch && instr_mem_address != last_fetch) begin
                check_fetch("instr_mem_address", instr_mem_address, last_fetch + 32'd4);
            end
            seen_fetch <= 1'b1;
            last_fetch <= instr_mem_address;
        end
        if (rst_n && instr_mem_resp && data_mem_resp && data_write) begin
            if (store_idx >= exp_addr.size()) begin
                $display("more data writes than the program contains");
                stop_on_failure();
            end else begin
                check_word("data_mem_address", data_mem_address, exp_addr[store_idx]);
                check_mask("data_mbe", data_mbe, exp_mbe[store_idx]);
                check_word("data_mem_wdata", data_mem_wdata & lane_bits(exp_mbe[store_idx]),
                           exp_data[store_idx]);
                store_idx <= store_idx + 1;
            end
        end
    end

    initial begin
        rst_n           = 1'b0;
        instr_mem_rdata = '0;
        instr_mem_resp  = 1'b0;
        data_mem_rdata  = '0;
        data_mem_resp   = 1'b0;
        i_wait          = 2'd0;
        d_wait          = 2'd0;
        seen_fetch      = 1'b0;
        last_fetch      = '0;
        store_idx       = 0;
        rng_state       = 32'h7b916d84;
        gen_program();
        run_model();
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fill_pattern(i);
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        while (!seen_fetch && cycles < FETCH_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!seen_fetch) begin
            $display("timeout waiting for the first instruction fetch response");
            stop_on_failure();
        end else begin
            cycles = 0;
            while (store_idx < exp_addr.size() && cycles < STORE_TIMEOUT) begin
                @(posedge clk);
                cycles++;
            end
            if (store_idx == exp_addr.size()) begin
                $display("Everything OK");
                $finish;
            end else begin
                $display("timeout with %0d of %0d stores seen", store_idx, exp_addr.size());
                stop_on_failure();
            end
        end
    end

endmodule : tb_cpu
